// File: logic/acc_pkg.sv
package acc_pkg;

    // Array and buffer sizes
    localparam int PE_SIZE   = 4;
    localparam int PSUM_ROWS = 3;
    localparam int ACC_TILES = 2;
    localparam int OUT_DEPTH = 4;

    // Counter widths derived from the sizes
    localparam int OUT_CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int ROW_W     = (PSUM_ROWS > 1) ? $clog2(PSUM_ROWS) : 1;
    localparam int TILE_W    = (ACC_TILES > 1) ? $clog2(ACC_TILES) : 1;

    typedef logic signed [7:0]  act_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [17:0] psum_t;
    typedef logic signed [23:0] ofmap_t;

    // Lane 0 sits in the low bits
    typedef struct packed {
        act_t [PE_SIZE-1:0] lane;
    } act_vec_t;

    typedef struct packed {
        weight_t [PE_SIZE-1:0] lane;
    } weight_row_t;

    typedef struct packed {
        psum_t [PE_SIZE-1:0] lane;
    } psum_vec_t;

    typedef struct packed {
        ofmap_t [PE_SIZE-1:0] lane;
    } ofmap_vec_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Byte offsets of the register map
    localparam logic [5:0] ADR_W0     = 6'h00;
    localparam logic [5:0] ADR_W1     = 6'h04;
    localparam logic [5:0] ADR_W2     = 6'h08;
    localparam logic [5:0] ADR_W3     = 6'h0C;
    localparam logic [5:0] ADR_ACT    = 6'h10;
    localparam logic [5:0] ADR_OUT0   = 6'h20;
    localparam logic [5:0] ADR_OUT1   = 6'h24;
    localparam logic [5:0] ADR_OUT2   = 6'h28;
    localparam logic [5:0] ADR_OUT3   = 6'h2C;
    localparam logic [5:0] ADR_STATUS = 6'h30;

endpackage

// File: logic/psum_queue.sv
module psum_queue #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clear,
    input  logic                         push,
    input  T                             din,
    input  logic                         pop,
    output T                             dout,
    output logic [$clog2(DEPTH+1)-1:0]   count,
    output logic                         full
);
    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    T     mem [DEPTH];
    ptr_t rd_ptr;
    ptr_t wr_ptr;
    logic do_push;
    logic do_pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full    = (count == cnt_t'(DEPTH));
    assign do_pop  = pop & (count != '0);
    // A pop in the same cycle frees the slot for the push
    assign do_push = push & (~full | do_pop);

    // Head is visible before the pop edge
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// File: logic/pe_row.sv
module pe_row (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  acc_pkg::weight_row_t [acc_pkg::PE_SIZE-1:0] weights,
    input  acc_pkg::act_vec_t                          act,
    input  logic                                       act_valid,
    output acc_pkg::psum_vec_t                         psum,
    output logic                                       psum_en
);
    import acc_pkg::*;

    psum_vec_t col_sum;

    // Column c collects a[r] * w[r][c] over all rows r
    always_comb begin
        col_sum = '0;
        for (int c = 0; c < PE_SIZE; c++) begin
            for (int r = 0; r < PE_SIZE; r++) begin
                col_sum.lane[c] = col_sum.lane[c]
                                + psum_t'(act.lane[r]) * psum_t'(weights[r].lane[c]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_en <= 1'b0;
        end else begin
            psum_en <= act_valid;
        end
    end

    // Sums only change when a new activation arrives
    always_ff @(posedge clk) begin
        if (act_valid) begin
            psum <= col_sum;
        end
    end

endmodule

// File: logic/acc_counter.sv
module acc_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic psum_en,
    output logic first_tile,
    output logic last_tile,
    output logic buf_clear
);
    import acc_pkg::*;

    logic [ROW_W-1:0]  row_cnt;
    logic [TILE_W-1:0] tile_cnt;
    logic              row_last;

    assign row_last = (row_cnt == ROW_W'(PSUM_ROWS - 1));

    // Row advances per vector; tile advances on row wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt  <= '0;
            tile_cnt <= '0;
        end else if (psum_en) begin
            if (row_last) begin
                row_cnt <= '0;
                if (last_tile) begin
                    tile_cnt <= '0;
                end else begin
                    tile_cnt <= tile_cnt + 1'b1;
                end
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Decode refers to the vector currently on psum_en
    assign first_tile = (tile_cnt == '0);
    assign last_tile  = (tile_cnt == TILE_W'(ACC_TILES - 1));

    // Group done, buffer pointers go back to zero
    assign buf_clear = psum_en & last_tile & row_last;

endmodule

// File: logic/psum_accumulator.sv
module psum_accumulator (
    input  acc_pkg::psum_vec_t  psum,
    input  logic                psum_en,
    input  logic                first_tile,
    input  logic                last_tile,
    input  acc_pkg::ofmap_vec_t buf_head,
    output logic                buf_pop,
    output logic                buf_push,
    output acc_pkg::ofmap_vec_t buf_data,
    output logic                out_push,
    output acc_pkg::ofmap_vec_t out_data
);
    import acc_pkg::*;

    ofmap_vec_t ext;
    ofmap_vec_t sum;
    ofmap_vec_t result;

    always_comb begin
        for (int i = 0; i < PE_SIZE; i++) begin
            ext.lane[i] = ofmap_t'(psum.lane[i]);
            sum.lane[i] = buf_head.lane[i] + ext.lane[i];
        end
    end

    // First tile starts from zero, later tiles add the buffered row
    assign result = first_tile ? ext : sum;

    // Nothing is buffered yet in the first tile
    assign buf_pop  = psum_en & ~first_tile;
    // Last tile sends the row out instead of back
    assign buf_push = psum_en & ~last_tile;
    assign out_push = psum_en & last_tile;

    assign buf_data = result;
    assign out_data = result;

endmodule

// File: logic/wb_acc_regs.sv
module wb_acc_regs (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  acc_pkg::wb_req_t                           wb_req,
    output acc_pkg::wb_rsp_t                           wb_rsp,
    output acc_pkg::weight_row_t [acc_pkg::PE_SIZE-1:0] weights,
    output acc_pkg::act_vec_t                          act,
    output logic                                       act_valid,
    input  logic                                       last_tile,
    input  acc_pkg::ofmap_vec_t                        out_head,
    input  logic [acc_pkg::OUT_CNT_W-1:0]              out_count,
    output logic                                       out_pop
);
    import acc_pkg::*;

    logic        ack;
    logic [31:0] rsp_dat;
    logic [31:0] rd_data;
    logic        req;
    logic        is_act;
    logic        stall;
    logic        take;
    logic        psum_pend;
    logic        out_full;
    logic        out_empty;

    // No new request while ack is up, so ack lasts one cycle
    assign req    = wb_req.cyc & wb_req.stb & ~ack;
    assign is_act = wb_req.we & (wb_req.adr == ADR_ACT);

    // Queue nearly full in the last tile.
    // Also hold off while a vector is still uncounted, its tile is not known yet
    assign stall = is_act
                 & (out_count >= OUT_CNT_W'(OUT_DEPTH - 1))
                 & (last_tile | psum_pend);
    assign take  = req & ~stall;

    // Reading the top lane releases the head vector
    assign out_pop = take & ~wb_req.we & (wb_req.adr == ADR_OUT3);

    assign out_full  = (out_count == OUT_CNT_W'(OUT_DEPTH));
    assign out_empty = (out_count == '0);

    always_comb begin
        case (wb_req.adr)
            ADR_W0, ADR_W1, ADR_W2, ADR_W3: begin
                rd_data = weights[wb_req.adr[3:2]];
            end
            ADR_OUT0, ADR_OUT1, ADR_OUT2, ADR_OUT3: begin
                rd_data = 32'(out_head.lane[wb_req.adr[3:2]]);
            end
            ADR_STATUS: begin
                rd_data = {{(28 - OUT_CNT_W){1'b0}}, out_count, 2'b00, out_full, out_empty};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            act_valid <= 1'b0;
            psum_pend <= 1'b0;
            weights   <= '0;
        end else begin
            ack       <= take;
            act_valid <= take & is_act;
            // Mirrors psum_en of the PE row
            psum_pend <= act_valid;
            if (take && wb_req.we && wb_req.adr[5:4] == 2'b00) begin
                weights[wb_req.adr[3:2]] <= weight_row_t'(wb_req.dat);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp_dat <= rd_data;
        end
        if (take && is_act) begin
            act <= act_vec_t'(wb_req.dat);
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rsp_dat;

endmodule

// File: logic/acc_top.sv
module acc_top (
    input  logic             clk,
    input  logic             rst_n,
    input  acc_pkg::wb_req_t wb_req,
    output acc_pkg::wb_rsp_t wb_rsp
);
    import acc_pkg::*;

    weight_row_t [PE_SIZE-1:0] weights;
    act_vec_t                  act;
    logic                      act_valid;
    psum_vec_t                 psum;
    logic                      psum_en;
    logic                      first_tile;
    logic                      last_tile;
    logic                      buf_clear;
    ofmap_vec_t                buf_head;
    ofmap_vec_t                buf_data;
    logic                      buf_pop;
    logic                      buf_push;
    ofmap_vec_t                out_head;
    ofmap_vec_t                out_data;
    logic                      out_push;
    logic                      out_pop;
    logic [OUT_CNT_W-1:0]      out_count;

    wb_acc_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .weights   (weights),
        .act       (act),
        .act_valid (act_valid),
        .last_tile (last_tile),
        .out_head  (out_head),
        .out_count (out_count),
        .out_pop   (out_pop)
    );

    pe_row u_pe_row (
        .clk       (clk),
        .rst_n     (rst_n),
        .weights   (weights),
        .act       (act),
        .act_valid (act_valid),
        .psum      (psum),
        .psum_en   (psum_en)
    );

    acc_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .psum_en    (psum_en),
        .first_tile (first_tile),
        .last_tile  (last_tile),
        .buf_clear  (buf_clear)
    );

    psum_accumulator u_accum (
        .psum       (psum),
        .psum_en    (psum_en),
        .first_tile (first_tile),
        .last_tile  (last_tile),
        .buf_head   (buf_head),
        .buf_pop    (buf_pop),
        .buf_push   (buf_push),
        .buf_data   (buf_data),
        .out_push   (out_push),
        .out_data   (out_data)
    );

    // One entry per row of a tile
    psum_queue #(.T(ofmap_vec_t), .DEPTH(PSUM_ROWS)) u_acc_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (buf_clear),
        .push  (buf_push),
        .din   (buf_data),
        .pop   (buf_pop),
        .dout  (buf_head),
        .count (),
        .full  ()
    );

    psum_queue #(.T(ofmap_vec_t), .DEPTH(OUT_DEPTH)) u_out_q (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (1'b0),
        .push  (out_push),
        .din   (out_data),
        .pop   (out_pop),
        .dout  (out_head),
        .count (out_count),
        .full  ()
    );

endmodule

// File: tb/tb_clock.sv
module tb_clock (
    output logic clk
);

    // 20 unit period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// File: tb/acc_checker.sv
module acc_checker (
    input logic                          clk,
    input logic                          rst_n,
    input acc_pkg::wb_req_t              wb_req,
    input acc_pkg::wb_rsp_t              wb_rsp,
    input logic [acc_pkg::OUT_CNT_W-1:0] out_count,
    input logic                          out_push,
    input logic                          out_pop,
    input logic                          psum_en,
    input logic                          buf_clear
);
    import acc_pkg::*;

    localparam int GROUP_LEN = ACC_TILES * PSUM_ROWS;

    int vec_cnt;

    // Own count of vectors within a group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vec_cnt <= 0;
        end else if (psum_en) begin
            vec_cnt <= (vec_cnt == GROUP_LEN - 1) ? 0 : vec_cnt + 1;
        end
    end

    // Ack answers a request seen on the edge before
    ack_has_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high for two cycles in a row");

    // A push into a full queue without a pop would be lost
    out_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_push && !out_pop |-> out_count < OUT_CNT_W'(OUT_DEPTH))
        else $error("output queue would grow past its depth");

    // Clear only on the final row of a group
    clear_with_psum: assert property (@(posedge clk) disable iff (!rst_n)
        buf_clear == (psum_en && vec_cnt == GROUP_LEN - 1))
        else $error("buffer clear not on the final vector of a group");

endmodule

// File: tb/acc_tb.sv
module acc_tb;
    import acc_pkg::*;

    // Several times the length of all tests
    localparam int MAX_CYCLES = 2000;
    localparam int GROUP_LEN  = ACC_TILES * PSUM_ROWS;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          seed = 32'he5d;
    int          cycles = 0;
    weight_row_t wts [PE_SIZE];
    act_vec_t    group_acts [GROUP_LEN];
    ofmap_vec_t  exp_q [$];

    tb_clock u_clk (.clk(clk));

    acc_top u_dut (.clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp));

    bind acc_top acc_checker u_checker (
        .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .out_count(out_count), .out_push(out_push), .out_pop(out_pop),
        .psum_en(psum_en), .buf_clear(buf_clear)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_ofmap(input string name, input ofmap_vec_t got, input ofmap_vec_t want);
        if (got !== want) begin
            fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, want));
        end
    endtask

    // Request held from just after an edge until ack shows up
    task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat, output int waits);
        waits = 0;
        @(posedge clk);
        #2;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(posedge clk);
            #2;
            waits++;
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        int          waits;
        bus_cycle(1'b1, adr, dat, ignored, waits);
    endtask

    // Reads are always answered on the next edge
    task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
        int waits;
        bus_cycle(1'b0, adr, '0, dat, waits);
        if (waits != 1) begin
            fail_run($sformatf("Register read at %h was acknowledged after %0d cycles",
                               adr, waits));
        end
    endtask

    // Status word: empty in bit 0, full in bit 1, count from bit 4
    task automatic check_status(input int want_count);
        logic [31:0] got;
        logic [31:0] want;
        wb_read(ADR_STATUS, got);
        want = 32'(want_count) << 4;
        want[1] = (want_count == OUT_DEPTH);
        want[0] = (want_count == 0);
        check_word("status", got, want);
    endtask

    // Column c of the PE row is the dot product of the vector with weight column c
    function automatic ofmap_vec_t dot_ref(input act_vec_t a);
        ofmap_vec_t r;
        int         s;
        for (int c = 0; c < PE_SIZE; c++) begin
            s = 0;
            for (int i = 0; i < PE_SIZE; i++) begin
                s += int'(a.lane[i]) * int'(wts[i].lane[c]);
            end
            r.lane[c] = ofmap_t'(s);
        end
        return r;
    endfunction

    // Random activations for one group, expected rows summed over the tiles
    task automatic make_group();
        ofmap_vec_t row_sum;
        ofmap_vec_t d;
        for (int k = 0; k < GROUP_LEN; k++) begin
            group_acts[k] = act_vec_t'($random(seed));
        end
        for (int r = 0; r < PSUM_ROWS; r++) begin
            row_sum = '0;
            for (int t = 0; t < ACC_TILES; t++) begin
                d = dot_ref(group_acts[t * PSUM_ROWS + r]);
                for (int c = 0; c < PE_SIZE; c++) begin
                    row_sum.lane[c] = row_sum.lane[c] + d.lane[c];
                end
            end
            exp_q.push_back(row_sum);
        end
    endtask

    // Reading the top lane pops the vector
    task automatic read_output();
        logic [31:0] w;
        ofmap_vec_t  got;
        for (int c = 0; c < PE_SIZE; c++) begin
            wb_read(ADR_OUT0 + 6'(4 * c), w);
            got.lane[c] = w[23:0];
        end
        if (exp_q.size() == 0) begin
            fail_run("An output vector was read with no result expected");
        end
        check_ofmap("out_vec", got, exp_q.pop_front());
    endtask

    task automatic reset_values();
        logic [31:0] w;
        check_status(0);
        for (int r = 0; r < PE_SIZE; r++) begin
            wb_read(ADR_W0 + 6'(4 * r), w);
            check_word("weight_row", w, '0);
        end
    endtask

    task automatic weight_readback();
        logic [31:0] w;
        for (int r = 0; r < PE_SIZE; r++) begin
            wts[r] = weight_row_t'($random(seed));
            wb_write(ADR_W0 + 6'(4 * r), wts[r]);
        end
        for (int r = 0; r < PE_SIZE; r++) begin
            wb_read(ADR_W0 + 6'(4 * r), w);
            check_word("weight_row", w, wts[r]);
        end
    endtask

    // New weights per group, results read back before the next one
    task automatic run_groups(input int n);
        for (int g = 0; g < n; g++) begin
            weight_readback();
            make_group();
            for (int k = 0; k < GROUP_LEN; k++) begin
                wb_write(ADR_ACT, group_acts[k]);
            end
            for (int r = 0; r < PSUM_ROWS; r++) begin
                read_output();
            end
            check_status(0);
        end
    endtask

    task automatic expect_stall(input logic [31:0] dat, input int n);
        @(posedge clk);
        #2;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: ADR_ACT, dat: dat};
        repeat (n) begin
            @(posedge clk);
            #2;
            if (wb_rsp.ack) begin
                fail_run("Activation write was acknowledged with the output queue nearly full");
            end
        end
        wb_req = '0;
    endtask

    // First group left unread, so every last-tile write of the second one waits for a pop
    task automatic out_queue_backpressure();
        make_group();
        for (int k = 0; k < GROUP_LEN; k++) begin
            wb_write(ADR_ACT, group_acts[k]);
        end
        make_group();
        for (int k = 0; k < GROUP_LEN - PSUM_ROWS; k++) begin
            wb_write(ADR_ACT, group_acts[k]);
        end
        for (int r = 0; r < PSUM_ROWS; r++) begin
            repeat (3) @(posedge clk);
            check_status(OUT_DEPTH - 1);
            expect_stall(group_acts[GROUP_LEN - PSUM_ROWS + r], 4);
            read_output();
            wb_write(ADR_ACT, group_acts[GROUP_LEN - PSUM_ROWS + r]);
        end
        repeat (3) @(posedge clk);
        check_status(PSUM_ROWS);
        for (int r = 0; r < PSUM_ROWS; r++) begin
            read_output();
        end
        check_status(0);
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $fatal(1, "timeout");
    end

    initial begin
        wb_req = '0;
        rst_n  = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reset_values();
        run_groups(1);
        run_groups(2);
        out_queue_backpressure();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: list.f
logic/acc_pkg.sv
logic/psum_queue.sv
logic/pe_row.sv
logic/acc_counter.sv
logic/psum_accumulator.sv
logic/wb_acc_regs.sv
logic/acc_top.sv
tb/tb_clock.sv
tb/acc_checker.sv
tb/acc_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module acc_tb -f list.f -Mdir obj_dir -o acc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/acc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0
